// File: Makefile
TOP := ledControllerTb

simulate:
	verilator --binary --timing --assert --timescale 1ns/100ps -f vlog.f --top-module $(TOP) -Mdir obj_dir
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "ALL TESTS PASSED"

clean:
	rm -rf obj_dir

.PHONY: simulate clean

// File: src/ledController.sv
// LED controller top level
module ledController #(
  parameter int fineBits = 4
) (
  input  logic                              clock,
  input  logic                              rstN,
  input  logic                              csrWrite,
  input  logic                              csrRead,
  input  logic [ledPkg::csrAddrBits-1:0]    csrAddr,
  input  logic [31:0]                       csrWdata,
  output logic [31:0]                       csrRdata,
  output logic [ledPkg::ledCount-1:0]       ledOut
);

  import ledPkg::*;

  // register file outputs
  logic [prescaleBits-1:0] prescale;
  logic [ledCount-1:0][modeBits-1:0] ledMode;
  logic [ledCount-1:0][paramBits-1:0] ledParam;

  // timebase levels
  logic [phaseBits-1:0] phase;
  logic [intraBits-1:0] intra;
  logic [stepBits-1:0] step;
  logic heartbeat;

  // settings
  ledCsr uCsr (
    .clock    (clock),
    .rstN     (rstN),
    .csrWrite (csrWrite),
    .csrRead  (csrRead),
    .csrAddr  (csrAddr),
    .csrWdata (csrWdata),
    .csrRdata (csrRdata),
    .prescale (prescale),
    .ledMode  (ledMode),
    .ledParam (ledParam)
  );

  // shared counters for all LEDs
  ledTimebase #(
    .fineBits (fineBits)
  ) uTimebase (
    .clock     (clock),
    .rstN      (rstN),
    .prescale  (prescale),
    .phase     (phase),
    .intra     (intra),
    .step      (step),
    .heartbeat (heartbeat)
  );

  // output stage
  ledDriver uDriver (
    .clock     (clock),
    .rstN      (rstN),
    .phase     (phase),
    .intra     (intra),
    .step      (step),
    .heartbeat (heartbeat),
    .ledMode   (ledMode),
    .ledParam  (ledParam),
    .ledOut    (ledOut)
  );

endmodule

// File: src/ledCsr.sv
// LED register file
module ledCsr (
  input  logic                                                clock,
  input  logic                                                rstN,
  input  logic                                                csrWrite,
  input  logic                                                csrRead,
  input  logic [ledPkg::csrAddrBits-1:0]                      csrAddr,
  input  logic [31:0]                                         csrWdata,
  output logic [31:0]                                         csrRdata,
  output logic [ledPkg::prescaleBits-1:0]                     prescale,
  output logic [ledPkg::ledCount-1:0][ledPkg::modeBits-1:0]   ledMode,
  output logic [ledPkg::ledCount-1:0][ledPkg::paramBits-1:0]  ledParam
);

  import ledPkg::*;

  // stored words, already masked on write
  logic [31:0] prescaleQ;
  logic [ledCount-1:0][31:0] ctrlQ;

  // address decode
  logic prescaleHit;
  logic idHit;
  logic [ledCount-1:0] ctrlHit;

  // read mux result before the output register
  logic [31:0] readWord;

  assign idHit = (csrAddr == addrId);
  assign prescaleHit = (csrAddr == addrPrescale);

  for (genvar i = 0; i < ledCount; i++) begin : gCtrl
    // one hit line per control word
    assign ctrlHit[i] = (csrAddr == (addrCtrlBase + csrAddrBits'(i)));

    // field extraction toward the driver
    assign ledMode[i] = ctrlQ[i][modeLsb +: modeBits];
    assign ledParam[i] = ctrlQ[i][paramLsb +: paramBits];
  end

  assign prescale = prescaleQ[prescaleBits-1:0];

  // writable registers
  // identity and unmapped addresses simply never match
  always_ff @(posedge clock or negedge rstN) begin
    if (!rstN) begin
      prescaleQ <= 32'(prescaleInit);
      ctrlQ <= '0;
    end else if (csrWrite) begin
      if (prescaleHit) begin
        prescaleQ <= csrWdata & prescaleMask;
      end
      for (int i = 0; i < ledCount; i++) begin
        if (ctrlHit[i]) begin
          ctrlQ[i] <= csrWdata & ctrlMask;
        end
      end
    end
  end

  // read mux, zero for anything unmapped
  always_comb begin
    readWord = '0;
    if (idHit) begin
      readWord = idValue;
    end else if (prescaleHit) begin
      readWord = prescaleQ;
    end
    for (int i = 0; i < ledCount; i++) begin
      if (ctrlHit[i]) begin
        readWord = ctrlQ[i];
      end
    end
  end

  // read data held until the next read strobe
  always_ff @(posedge clock or negedge rstN) begin
    if (!rstN) begin
      csrRdata <= '0;
    end else if (csrRead) begin
      csrRdata <= readWord;
    end
  end

  // read data only moves right after a read
  rdataStable: assert property (
    @(posedge clock) disable iff (!rstN)
    !$past(csrRead) |-> $stable(csrRdata)
  );

endmodule

// File: src/ledDriver.sv
// per LED output driver
module ledDriver (
  input  logic                                                clock,
  input  logic                                                rstN,
  input  logic [ledPkg::phaseBits-1:0]                        phase,
  input  logic [ledPkg::intraBits-1:0]                        intra,
  input  logic [ledPkg::stepBits-1:0]                         step,
  input  logic                                                heartbeat,
  input  logic [ledPkg::ledCount-1:0][ledPkg::modeBits-1:0]   ledMode,
  input  logic [ledPkg::ledCount-1:0][ledPkg::paramBits-1:0]  ledParam,
  output logic [ledPkg::ledCount-1:0]                         ledOut
);

  import ledPkg::*;

  // one flop per LED
  always_ff @(posedge clock or negedge rstN) begin
    if (!rstN) begin
      ledOut <= '0;
    end else begin
      for (int i = 0; i < ledCount; i++) begin
        case (ledMode[i])
          // pwm, brightness compared against phase
          modeOn:
            ledOut[i] <= (ledParam[i] >= phase);
          // second half of each step below the blink count
          modeBlink:
            ledOut[i] <= (ledParam[i] > paramBits'(step)) && intra[intraBits-1];
          // heartbeat gated by a coarse 2-bit brightness
          modeHeartbeat:
            ledOut[i] <= heartbeat && (ledParam[i][paramBits-1 -: 2] >= intra[1:0]);
          default:
            ledOut[i] <= 1'b0;
        endcase
      end
    end
  end

  for (genvar i = 0; i < ledCount; i++) begin : gCheck
    // off mode forces the LED dark on the next edge
    offIsDark: assert property (
      @(posedge clock) disable iff (!rstN)
      (ledMode[i] == modeOff) |=> !ledOut[i]
    );
  end

endmodule

// File: src/ledPkg.sv
// LED controller shared definitions
package ledPkg;

  // number of driven LEDs
  localparam int ledCount = 4;

  // register map
  localparam int csrAddrBits = 3;
  localparam logic [csrAddrBits-1:0] addrId = 3'd0;
  localparam logic [csrAddrBits-1:0] addrPrescale = 3'd1;
  // control word of LED i lives at addrCtrlBase + i
  localparam logic [csrAddrBits-1:0] addrCtrlBase = 3'd2;

  // control word layout
  localparam int modeLsb = 0;
  localparam int modeBits = 2;
  localparam int paramLsb = 8;
  localparam int paramBits = 6;

  // identity word, block code over zero byte over LED count
  localparam logic [15:0] idBlockCode = 16'h4c45;
  localparam logic [31:0] idValue = {idBlockCode, 8'h00, 8'(ledCount)};

  // prescale word
  localparam int prescaleBits = 10;
  localparam logic [31:0] prescaleMask = 32'((1 << prescaleBits) - 1);
  localparam int minPrescale = 2;

  // only mode and parameter fields are writable
  localparam logic [31:0] ctrlMask = (32'((1 << paramBits) - 1) << paramLsb) |
                                     (32'((1 << modeBits) - 1) << modeLsb);

  // mode codes
  localparam logic [modeBits-1:0] modeOff = 2'd0;
  localparam logic [modeBits-1:0] modeOn = 2'd1;
  localparam logic [modeBits-1:0] modeBlink = 2'd2;
  localparam logic [modeBits-1:0] modeHeartbeat = 2'd3;

  // reset prescale gives roughly a one second period
  localparam int clockHz = 25_000_000;
  localparam int prescaleInit = clockHz / 2_097_152;

  // timebase counter widths
  localparam int phaseBits = 6;
  localparam int intraBits = 8;
  localparam int stepBits = 3;

endpackage

// File: src/ledTimebase.sv
// LED timebase and heartbeat
module ledTimebase #(
  parameter int fineBits = 4
) (
  input  logic                              clock,
  input  logic                              rstN,
  input  logic [ledPkg::prescaleBits-1:0]   prescale,
  output logic [ledPkg::phaseBits-1:0]      phase,
  output logic [ledPkg::intraBits-1:0]      intra,
  output logic [ledPkg::stepBits-1:0]       step,
  output logic                              heartbeat
);

  import ledPkg::*;

  // fine division and phase share one counter
  localparam int fineTop = fineBits + phaseBits;

  logic [prescaleBits-1:0] effPrescale;
  logic [prescaleBits-1:0] preCount;
  logic prescalePulse;
  logic [fineTop-1:0] fineCount;
  logic phaseWrap;
  logic intraWrap;
  // brightness ramp from the upper intra bits
  logic [phaseBits-1:0] rampLevel;

  // clamp tiny prescale values
  assign effPrescale = (prescale < prescaleBits'(minPrescale)) ?
                       prescaleBits'(minPrescale) : prescale;

  // pulse on the last count, >= covers a prescale that shrank mid count
  assign prescalePulse = (preCount >= (effPrescale - 1'b1));

  always_ff @(posedge clock or negedge rstN) begin
    if (!rstN) begin
      preCount <= '0;
    end else if (prescalePulse) begin
      preCount <= '0;
    end else begin
      preCount <= preCount + 1'b1;
    end
  end

  // cascade strobes
  assign phaseWrap = prescalePulse && (&fineCount);
  assign intraWrap = phaseWrap && (&intra);

  // fine bits below, 64 phases on top
  always_ff @(posedge clock or negedge rstN) begin
    if (!rstN) begin
      fineCount <= '0;
    end else if (prescalePulse) begin
      fineCount <= fineCount + 1'b1;
    end
  end

  assign phase = fineCount[fineTop-1 -: phaseBits];

  // intra step and step counters
  always_ff @(posedge clock or negedge rstN) begin
    if (!rstN) begin
      intra <= '0;
      step <= '0;
    end else begin
      if (phaseWrap) begin
        intra <= intra + 1'b1;
      end
      if (intraWrap) begin
        step <= step + 1'b1;
      end
    end
  end

  assign rampLevel = intra[intraBits-1 -: phaseBits];

  // up, down, up, down, then dark for steps 4 to 7
  always_ff @(posedge clock or negedge rstN) begin
    if (!rstN) begin
      heartbeat <= 1'b0;
    end else if (step[2]) begin
      heartbeat <= 1'b0;
    end else if (step[0]) begin
      heartbeat <= (~rampLevel > phase);
    end else begin
      heartbeat <= (rampLevel > phase);
    end
  end

  // min prescale of 2 keeps pulses apart
  pulseIsolated: assert property (
    @(posedge clock) disable iff (!rstN)
    prescalePulse |=> !prescalePulse
  );

  // step only advances out of a full intra sweep
  stepOnWrap: assert property (
    @(posedge clock) disable iff (!rstN)
    $changed(step) |-> ($past(intra) == '1) && (intra == '0)
  );

endmodule

// File: verif/ledControllerTb.sv
// LED controller testbench
module ledControllerTb;

  timeunit 1ns;
  timeprecision 100ps;

  import ledPkg::*;

  // prescale of 2 and no fine division
  localparam int presc = 2;
  localparam int periodT = 64 * presc;
  localparam int fullPeriod = 2048 * periodT;
  localparam int blinkLen = 128 * periodT;
  localparam int darkLen = 1024 * periodT;
  // register tests plus one period for on and blink and up to two for heartbeat
  localparam int timeoutLimit = 3 * fullPeriod + 2000;

  // expected register values from the register map
  localparam logic [31:0] expPrescaleInit = 32'(25_000_000 / 2_097_152);
  localparam logic [31:0] expPrescaleMask = 32'h0000_03ff;
  localparam logic [31:0] expCtrlMask = 32'h0000_3f03;

  // on mode brightness per LED
  localparam int bright0 = 20;
  localparam int bright1 = 63;

  logic clock;
  logic rstN;
  logic csrWrite;
  logic csrRead;
  logic [csrAddrBits-1:0] csrAddr;
  logic [31:0] csrWdata;
  logic [31:0] csrRdata;
  logic [ledCount-1:0] ledOut;

  // window state written only by the sampling block
  int cycleCount = 0;
  int winAck = 0;
  int winDone = 0;
  int winLeft = 0;
  int highCount [ledCount];
  int riseCount [ledCount];
  int sliceLeft = 0;
  int slice0 = 0;
  int slice1 = 0;
  int blinkRun = 0;
  bit blinkOpen = 0;
  int lowRun = 0;
  int maxLow = 0;
  bit seenHigh = 0;
  logic [ledCount-1:0] prevOut = '0;
  int onErrs = 0;
  int blinkErrs = 0;

  // stimulus side
  int winReq = 0;
  int winLength = 0;
  bit onCheck = 0;
  bit blinkCheck = 0;
  bit hbCheck = 0;
  int taskErrs = 0;
  int hbErrs = 0;
  int passCount = 0;
  int failCount = 0;
  int seed = 32'h1b1a;
  int blinkCount = 0;

  ledController #(
    .fineBits (0)
  ) UUT (
    .clock    (clock),
    .rstN     (rstN),
    .csrWrite (csrWrite),
    .csrRead  (csrRead),
    .csrAddr  (csrAddr),
    .csrWdata (csrWdata),
    .csrRdata (csrRdata),
    .ledOut   (ledOut)
  );

  always #20 clock = ~clock;

  // PWM duty per T window is (brightness + 1) phases of presc cycles
  function automatic int onHighCount(input int param);
    return (param + 1) * presc;
  endfunction

  function automatic logic [31:0] ctrlWord(input logic [1:0] mode, input int param);
    return (32'(param) << 8) | 32'(mode);
  endfunction

  // LED 3 glows wherever the dimmer LED 0 glows in heartbeat
  hbNested: assert property (
    @(posedge clock) disable iff (!hbCheck)
    ledOut[0] |-> ledOut[3]
  ) else begin
    hbErrs++;
    $display("FAILED at %0d ns: ledOut[0] is high while ledOut[3] is low", $time);
  end

  // window counters sampled away from the active edge
  always @(negedge clock) begin
    cycleCount++;
    if (cycleCount >= timeoutLimit) begin
      $display("timeout: the run did not finish within %0d cycles", cycleCount);
      $display("SOME TESTS FAILED");
      $finish;
    end else begin
      // new request opens a window on this sample
      if (winReq != winAck) begin
        winAck = winReq;
        winLeft = winLength;
        sliceLeft = periodT;
        slice0 = 0;
        slice1 = 0;
        blinkOpen = 0;
        seenHigh = 0;
        lowRun = 0;
        maxLow = 0;
        for (int i = 0; i < ledCount; i++) begin
          highCount[i] = 0;
          riseCount[i] = 0;
        end
      end
      if (winLeft > 0) begin
        for (int i = 0; i < ledCount; i++) begin
          highCount[i] += int'(ledOut[i]);
          riseCount[i] += int'(ledOut[i] && !prevOut[i]);
        end
        // duty over each T slice
        slice0 += int'(ledOut[0]);
        slice1 += int'(ledOut[1]);
        sliceLeft--;
        if (sliceLeft == 0) begin
          if (onCheck) begin
            assert (slice0 == onHighCount(bright0)) else begin
              onErrs++;
              $display("FAILED at %0d ns: ledOut[0] high cycles per T = %0d, expected %0d",
                       $time, slice0, onHighCount(bright0));
            end
            assert (slice1 == onHighCount(bright1)) else begin
              onErrs++;
              $display("FAILED at %0d ns: ledOut[1] high cycles per T = %0d, expected %0d",
                       $time, slice1, onHighCount(bright1));
            end
          end
          slice0 = 0;
          slice1 = 0;
          sliceLeft = periodT;
        end
        // blink length of runs that began inside the window
        if (ledOut[2] && !prevOut[2]) begin
          blinkOpen = 1;
          blinkRun = 1;
        end else if (ledOut[2]) begin
          blinkRun++;
        end else if (prevOut[2] && blinkOpen) begin
          blinkOpen = 0;
          if (blinkCheck) begin
            assert (blinkRun == blinkLen) else begin
              blinkErrs++;
              $display("FAILED at %0d ns: ledOut[2] blink length = %0d, expected %0d",
                       $time, blinkRun, blinkLen);
            end
          end
        end
        // longest dark stretch of LED 3 after its first high sample
        if (ledOut[3]) begin
          seenHigh = 1;
          lowRun = 0;
        end else if (seenHigh) begin
          lowRun++;
          if (lowRun > maxLow) begin
            maxLow = lowRun;
          end
        end
        winLeft--;
        if (winLeft == 0) begin
          winDone = winAck;
        end
      end
      prevOut = ledOut;
    end
  end

  task automatic writeReg(input logic [csrAddrBits-1:0] addr, input logic [31:0] data);
    @(posedge clock);
    #2;
    csrWrite = 1'b1;
    csrAddr = addr;
    csrWdata = data;
    @(posedge clock);
    #2;
    csrWrite = 1'b0;
  endtask

  task automatic readReg(input logic [csrAddrBits-1:0] addr, output logic [31:0] data);
    @(posedge clock);
    #2;
    csrRead = 1'b1;
    csrAddr = addr;
    @(posedge clock);
    #2;
    csrRead = 1'b0;
    // registered data valid one cycle after the strobe
    data = csrRdata;
  endtask

  task automatic checkWord(input string name, input logic [31:0] got, input logic [31:0] exp);
    assert (got == exp) else begin
      taskErrs++;
      $display("FAILED at %0d ns: %s = 0x%08h, expected 0x%08h", $time, name, got, exp);
    end
  endtask

  task automatic checkCount(input string name, input int got, input int exp);
    assert (got == exp) else begin
      taskErrs++;
      $display("FAILED at %0d ns: %s = %0d, expected %0d", $time, name, got, exp);
    end
  endtask

  task automatic checkAbove(input string name, input int got, input int floor);
    assert (got > floor) else begin
      taskErrs++;
      $display("FAILED at %0d ns: %s = %0d, expected above %0d", $time, name, got, floor);
    end
  endtask

  task automatic waitCycles(input int n);
    repeat (n) @(posedge clock);
  endtask

  // hand a window to the sampling block and wait for it to close
  task automatic runWindow(input int len);
    @(posedge clock);
    winLength = len;
    winReq++;
    while (winDone != winReq) begin
      @(posedge clock);
    end
  endtask

  task automatic waitLedRise(input int idx);
    logic last;
    @(negedge clock);
    last = ledOut[idx];
    @(negedge clock);
    while (!(ledOut[idx] && !last)) begin
      last = ledOut[idx];
      @(negedge clock);
    end
  endtask

  task automatic finishTest(input string name, input int errs);
    if (errs == 0) begin
      passCount++;
      $display("test %s: ok", name);
    end else begin
      failCount++;
      $display("test %s: %0d errors", name, errs);
    end
  endtask

  task automatic registerTest();
    logic [31:0] word;
    checkWord("ledOut after reset", 32'(ledOut), 32'h0);
    readReg(addrId, word);
    checkWord("csrRdata identity", word, idValue);
    readReg(addrPrescale, word);
    checkWord("csrRdata prescale reset", word, expPrescaleInit);
    writeReg(addrPrescale, '1);
    readReg(addrPrescale, word);
    checkWord("csrRdata prescale mask", word, expPrescaleMask);
    for (int i = 0; i < ledCount; i++) begin
      writeReg(addrCtrlBase + 3'(i), '1);
      readReg(addrCtrlBase + 3'(i), word);
      checkWord("csrRdata control mask", word, expCtrlMask);
    end
    // identity is read only
    writeReg(addrId, '1);
    readReg(addrId, word);
    checkWord("csrRdata identity after write", word, idValue);
    readReg(3'd7, word);
    checkWord("csrRdata unmapped", word, 32'h0);
  endtask

  initial begin
    int e0;
    int expBlinks;
    clock = 1'b0;
    rstN = 1'b0;
    csrWrite = 1'b0;
    csrRead = 1'b0;
    csrAddr = '0;
    csrWdata = '0;
    repeat (2) @(posedge clock);
    #2;
    rstN = 1'b1;

    e0 = taskErrs;
    registerTest();
    finishTest("registers", taskErrs - e0);

    // on, blink and off share one full period
    blinkCount = int'($unsigned($random(seed)) % 8) + 1;
    expBlinks = (blinkCount < 8) ? blinkCount : 8;
    writeReg(addrPrescale, 32'(presc));
    writeReg(addrCtrlBase, ctrlWord(modeOn, bright0));
    writeReg(addrCtrlBase + 3'd1, ctrlWord(modeOn, bright1));
    writeReg(addrCtrlBase + 3'd2, ctrlWord(modeBlink, blinkCount));
    writeReg(addrCtrlBase + 3'd3, ctrlWord(modeOff, 0));
    waitCycles(2);
    onCheck = 1;
    blinkCheck = 1;
    runWindow(fullPeriod);
    onCheck = 0;
    blinkCheck = 0;

    e0 = taskErrs;
    checkCount("ledOut[3] high cycles", highCount[3], 0);
    finishTest("off", taskErrs - e0);
    finishTest("on", onErrs);
    e0 = taskErrs;
    checkCount("ledOut[2] rising edges", riseCount[2], expBlinks);
    checkCount("ledOut[2] high cycles", highCount[2], expBlinks * blinkLen);
    finishTest("blink", taskErrs - e0 + blinkErrs);

    // heartbeat dim on LED 0 and bright on LED 3
    e0 = taskErrs;
    writeReg(addrCtrlBase + 3'd3, ctrlWord(modeHeartbeat, 48));
    writeReg(addrCtrlBase, ctrlWord(modeHeartbeat, 0));
    waitCycles(2);
    hbCheck = 1;
    // start on a rising edge so no dark stretch straddles the window
    waitLedRise(3);
    runWindow(fullPeriod);
    hbCheck = 0;
    checkAbove("ledOut[3] high cycles", highCount[3], 0);
    checkAbove("ledOut[3] high cycles over ledOut[0]", highCount[3], highCount[0]);
    checkAbove("ledOut[3] longest low stretch", maxLow, darkLen - 1);
    finishTest("heartbeat", taskErrs - e0 + hbErrs);

    $display("summary: passed %0d, failed %0d", passCount, failCount);
    if (failCount == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

// File: vlog.f
src/ledPkg.sv
src/ledCsr.sv
src/ledTimebase.sv
src/ledDriver.sv
src/ledController.sv
verif/ledControllerTb.sv
